// ==== pam4_link_pkg.sv ====
`default_nettype none

package pam4_link_pkg;

    // signed sample width on the channel side
    parameter int SAMPLE_W = 10;

    // taps are Q1.6, 64 is unity gain
    parameter int TAP_W = 8;
    parameter int TAP_FRAC = 6;

    parameter int NUM_TAPS_DEF = 4;
    parameter int SYMBOL_SEP_DEF = 56;

    // mapper, channel and slicer stages behind the source
    parameter int DRAIN_CYCLES = 3;

    typedef logic [1:0] pam4_sym_t;
    typedef logic signed [TAP_W-1:0] tap_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        pam4_sym_t sym;
        sample_t   level;
    } link_sample_t;

    typedef struct packed {
        logic      valid;
        pam4_sym_t tx_sym;
        pam4_sym_t rx_sym;
        sample_t   sample;
    } rx_obs_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        DRAIN,
        DONE
    } fsm_state_t;

    // level table, symbol s sits at (2s-3)*sep/2
    function automatic sample_t pam4_level(pam4_sym_t s, int sep);
        int v;
        v = ((2 * int'(s) - 3) * sep) / 2;
        return sample_t'(v);
    endfunction

    // thresholds at -sep, 0 and +sep
    function automatic int pam4_threshold(int idx, int sep);
        return (idx - 1) * sep;
    endfunction

    // decision is the number of thresholds the sample reaches
    function automatic pam4_sym_t pam4_decide(sample_t x, int sep);
        int v;
        int d;
        v = int'(x);
        d = 0;
        for (int i = 0; i < 3; i++) begin
            if (v >= pam4_threshold(i, sep)) begin
                d++;
            end
        end
        return pam4_sym_t'(d);
    endfunction

endpackage

`default_nettype wire

// ==== prbs_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module prbs_source (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     reseed,
    input  logic                     en,
    output pam4_link_pkg::pam4_sym_t sym,
    output logic                     sym_valid
);
    import pam4_link_pkg::*;

    localparam logic [6:0] SEED = 7'h7F;

    logic [6:0] lfsr;
    logic [6:0] lfsr_next;
    logic       bit_first;
    logic       bit_second;

    // x^7 + x^6 + 1, two steps per symbol
    assign bit_first  = lfsr[6] ^ lfsr[5];
    assign bit_second = lfsr[5] ^ lfsr[4];
    assign lfsr_next  = {lfsr[4:0], bit_first, bit_second};

    always_ff @(posedge clk) begin
        if (!rstn || reseed) begin
            lfsr      <= SEED;
            sym_valid <= 1'b0;
        end else begin
            sym_valid <= en;
            if (en) begin
                lfsr <= lfsr_next;
            end
        end
    end

    // first bit out of the register becomes the msb
    always_ff @(posedge clk) begin
        if (en) begin
            sym <= {bit_first, bit_second};
        end
    end

endmodule

`default_nettype wire

// ==== pam4_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam4_mapper #(
    parameter int SYMBOL_SEP = pam4_link_pkg::SYMBOL_SEP_DEF
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  pam4_link_pkg::pam4_sym_t    sym,
    input  logic                        sym_valid,
    output pam4_link_pkg::link_sample_t tx,
    output logic                        tx_valid
);
    import pam4_link_pkg::*;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= sym_valid;
        end
    end

    // symbol rides along so the slicer can compare without a delay line
    always_ff @(posedge clk) begin
        if (sym_valid) begin
            tx.sym   <= sym;
            tx.level <= pam4_level(sym, SYMBOL_SEP);
        end
    end

endmodule

`default_nettype wire

// ==== isi_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module isi_channel #(
    parameter int NUM_TAPS = pam4_link_pkg::NUM_TAPS_DEF
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                flush,
    input  logic                                load_taps,
    input  pam4_link_pkg::tap_t [NUM_TAPS-1:0] taps,
    input  pam4_link_pkg::link_sample_t         din,
    input  logic                                din_valid,
    output pam4_link_pkg::link_sample_t         dout,
    output logic                                dout_valid
);
    import pam4_link_pkg::*;

    // room for the full sum of products plus sign
    localparam int ACC_W = SAMPLE_W + TAP_W + $clog2(NUM_TAPS) + 1;
    localparam logic signed [ACC_W-1:0] SAT_HI = ACC_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] SAT_LO = -ACC_W'(2 ** (SAMPLE_W - 1));

    tap_t [NUM_TAPS-1:0]     taps_q;
    // hist[k] holds the level from k symbols ago
    sample_t                 hist [1:NUM_TAPS-1];
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] scaled;
    sample_t                 sat;

    always_ff @(posedge clk) begin
        if (load_taps) begin
            taps_q <= taps;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            for (int k = 1; k < NUM_TAPS; k++) begin
                hist[k] <= '0;
            end
        end else if (din_valid) begin
            for (int k = NUM_TAPS - 1; k > 1; k--) begin
                hist[k] <= hist[k-1];
            end
            hist[1] <= din.level;
        end
    end

    // main cursor on the current level, post-cursors on the history
    always_comb begin
        acc = ACC_W'(taps_q[0]) * ACC_W'(din.level);
        for (int k = 1; k < NUM_TAPS; k++) begin
            acc = acc + ACC_W'(taps_q[k]) * ACC_W'(hist[k]);
        end
        // floor division by 64
        scaled = acc >>> TAP_FRAC;
        if (scaled > SAT_HI) begin
            sat = sample_t'(SAT_HI);
        end else if (scaled < SAT_LO) begin
            sat = sample_t'(SAT_LO);
        end else begin
            sat = sample_t'(scaled);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            dout.sym   <= din.sym;
            dout.level <= sat;
        end
    end

endmodule

`default_nettype wire

// ==== pam4_slicer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam4_slicer #(
    parameter int SYMBOL_SEP = pam4_link_pkg::SYMBOL_SEP_DEF
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        clear_errors,
    input  pam4_link_pkg::link_sample_t din,
    input  logic                        din_valid,
    output pam4_link_pkg::rx_obs_t      obs,
    output logic [15:0]                 error_count
);
    import pam4_link_pkg::*;

    pam4_sym_t decided;
    logic      obs_valid;
    pam4_sym_t tx_q;
    pam4_sym_t rx_q;
    sample_t   sample_q;

    assign decided = pam4_decide(din.level, SYMBOL_SEP);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            obs_valid   <= 1'b0;
            error_count <= '0;
        end else begin
            obs_valid <= din_valid;
            if (clear_errors) begin
                error_count <= '0;
            end else if (din_valid && decided != din.sym && error_count != 16'hFFFF) begin
                // stops at full scale
                error_count <= error_count + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            tx_q     <= din.sym;
            rx_q     <= decided;
            sample_q <= din.level;
        end
    end

    assign obs = '{valid: obs_valid, tx_sym: tx_q, rx_sym: rx_q, sample: sample_q};

endmodule

`default_nettype wire

// ==== burst_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_counter (
    input  logic        clk,
    input  logic        rstn,
    input  logic        load,
    input  logic        en,
    input  logic [15:0] value,
    output logic        zero
);

    logic [15:0] count;

    // load wins over en, so a reload can share a cycle with the last count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (load) begin
            count <= value - 16'd1;
        end else if (en && count != 16'd0) begin
            count <= count - 16'd1;
        end
    end

    // marks the last enabled cycle of a phase
    assign zero = en && (count == 16'd0);

endmodule

`default_nettype wire

// ==== link_test_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_test_fsm (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic cnt_zero,
    output logic busy,
    output logic done,
    output logic reseed,
    output logic flush,
    output logic load_taps,
    output logic clear_errors,
    output logic tx_en,
    output logic cnt_load,
    output logic cnt_en,
    output logic cnt_sel_drain
);
    import pam4_link_pkg::*;

    fsm_state_t state;
    fsm_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // start is only looked at here, so a pulse while busy is dropped
            IDLE:    if (start) state_next = LOAD;
            LOAD:    state_next = RUN;
            RUN:     if (cnt_zero) state_next = DRAIN;
            DRAIN:   if (cnt_zero) state_next = DONE;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // burst setup all happens in the single load cycle
    assign reseed       = (state == LOAD);
    assign flush        = (state == LOAD);
    assign load_taps    = (state == LOAD);
    assign clear_errors = (state == LOAD);

    assign tx_en  = (state == RUN);
    assign cnt_en = (state == RUN) || (state == DRAIN);

    // reload for the drain on the last run cycle
    assign cnt_load      = (state == LOAD) || (state == RUN && cnt_zero);
    assign cnt_sel_drain = (state == RUN);

    assign busy = (state == LOAD) || (state == RUN) || (state == DRAIN);
    assign done = (state == DONE);

endmodule

`default_nettype wire

// ==== pam4_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam4_link_top #(
    parameter int NUM_TAPS   = pam4_link_pkg::NUM_TAPS_DEF,
    parameter int SYMBOL_SEP = pam4_link_pkg::SYMBOL_SEP_DEF
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                start,
    input  logic [15:0]                         burst_len,
    input  pam4_link_pkg::tap_t [NUM_TAPS-1:0] taps,
    output logic                                busy,
    output logic                                done,
    output logic [15:0]                         error_count,
    output pam4_link_pkg::rx_obs_t              rx_obs
);
    import pam4_link_pkg::*;

    // the source's own output register adds one stage to the drain
    localparam logic [15:0] DRAIN_LOAD = 16'(DRAIN_CYCLES + 1);

    logic         reseed;
    logic         flush;
    logic         load_taps;
    logic         clear_errors;
    logic         tx_en;
    logic         cnt_load;
    logic         cnt_en;
    logic         cnt_sel_drain;
    logic         cnt_zero;
    logic [15:0]  cnt_value;
    pam4_sym_t    sym;
    logic         sym_valid;
    link_sample_t tx_sample;
    logic         tx_valid;
    link_sample_t ch_sample;
    logic         ch_valid;

    assign cnt_value = cnt_sel_drain ? DRAIN_LOAD : burst_len;

    link_test_fsm link_test_fsm_i (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .cnt_zero      (cnt_zero),
        .busy          (busy),
        .done          (done),
        .reseed        (reseed),
        .flush         (flush),
        .load_taps     (load_taps),
        .clear_errors  (clear_errors),
        .tx_en         (tx_en),
        .cnt_load      (cnt_load),
        .cnt_en        (cnt_en),
        .cnt_sel_drain (cnt_sel_drain)
    );

    burst_counter burst_counter_i (
        .clk   (clk),
        .rstn  (rstn),
        .load  (cnt_load),
        .en    (cnt_en),
        .value (cnt_value),
        .zero  (cnt_zero)
    );

    prbs_source prbs_source_i (
        .clk       (clk),
        .rstn      (rstn),
        .reseed    (reseed),
        .en        (tx_en),
        .sym       (sym),
        .sym_valid (sym_valid)
    );

    pam4_mapper #(
        .SYMBOL_SEP (SYMBOL_SEP)
    ) pam4_mapper_i (
        .clk       (clk),
        .rstn      (rstn),
        .sym       (sym),
        .sym_valid (sym_valid),
        .tx        (tx_sample),
        .tx_valid  (tx_valid)
    );

    isi_channel #(
        .NUM_TAPS (NUM_TAPS)
    ) isi_channel_i (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .load_taps  (load_taps),
        .taps       (taps),
        .din        (tx_sample),
        .din_valid  (tx_valid),
        .dout       (ch_sample),
        .dout_valid (ch_valid)
    );

    pam4_slicer #(
        .SYMBOL_SEP (SYMBOL_SEP)
    ) pam4_slicer_i (
        .clk          (clk),
        .rstn         (rstn),
        .clear_errors (clear_errors),
        .din          (ch_sample),
        .din_valid    (ch_valid),
        .obs          (rx_obs),
        .error_count  (error_count)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 10
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== pam4_link_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam4_link_sva (
    input logic                       clk,
    input logic                       rstn,
    input logic                       start,
    input logic                       cnt_zero,
    input logic                       busy,
    input logic                       done,
    input logic                       tx_en,
    input pam4_link_pkg::fsm_state_t state
);
    import pam4_link_pkg::*;

    int assert_errors;

    done_single_cycle: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_errors++;
        end

    // symbols go out from the cycle after load up to the last counted run cycle
    tx_only_in_run: assert property (@(posedge clk) disable iff (!rstn)
        tx_en |-> $past(state) == LOAD || $past(tx_en && !cnt_zero))
        else begin
            $error("tx_en high outside a run that started after load");
            assert_errors++;
        end

    // busy rises in load, one cycle after the accepted start
    busy_after_start: assert property (@(posedge clk) disable iff (!rstn)
        $rose(busy) |-> $past(start))
        else begin
            $error("busy rose without a start pulse in the previous cycle");
            assert_errors++;
        end

endmodule

bind link_test_fsm pam4_link_sva pam4_link_sva_i (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start),
    .cnt_zero (cnt_zero),
    .busy     (busy),
    .done     (done),
    .tx_en    (tx_en),
    .state    (state)
);

`default_nettype wire

// ==== pam4_link_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam4_link_checker #(
    parameter int NUM_TAPS   = pam4_link_pkg::NUM_TAPS_DEF,
    parameter int SYMBOL_SEP = pam4_link_pkg::SYMBOL_SEP_DEF
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                start,
    input  logic [15:0]                         burst_len,
    input  pam4_link_pkg::tap_t [NUM_TAPS-1:0] taps,
    input  logic                                busy,
    input  logic                                done,
    input  logic [15:0]                         error_count,
    input  pam4_link_pkg::rx_obs_t              rx_obs,
    input  logic [8*12-1:0]                     test_name,
    input  logic                                exp_nonzero,
    output int                                  value_errors,
    output int                                  protocol_errors
);
    import pam4_link_pkg::*;

    localparam int SAT_MAX = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SAT_MIN = -(2 ** (SAMPLE_W - 1));
    localparam int UNITY   = 1 << TAP_FRAC;

    logic [6:0] lfsr;
    int         tap_q [NUM_TAPS];
    int         hist [NUM_TAPS];
    int         exp_errors;
    int         obs_count;
    int         exp_len;
    logic       busy_q;
    logic       in_burst;
    logic       started;

    function automatic int floor_scale(int x);
        int q;
        q = x / UNITY;
        if (x < 0 && q * UNITY != x) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic int clamp_sample(int x);
        if (x > SAT_MAX) begin
            return SAT_MAX;
        end
        if (x < SAT_MIN) begin
            return SAT_MIN;
        end
        return x;
    endfunction

    // one step up per threshold reached
    function automatic int slice(int x);
        int d;
        d = 0;
        if (x >= -SYMBOL_SEP) d++;
        if (x >= 0) d++;
        if (x >= SYMBOL_SEP) d++;
        return d;
    endfunction

    // x^7 + x^6 + 1, first bit lands in the msb
    task automatic advance_prbs(output int sym);
        logic b;
        sym = 0;
        for (int i = 0; i < 2; i++) begin
            b = lfsr[6] ^ lfsr[5];
            lfsr = {lfsr[5:0], b};
            sym = sym * 2 + int'(b);
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            value_errors++;
            $display("error %0s %0s: expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    always @(posedge clk) begin : monitor
        int sym;
        int level;
        int acc;
        int sample;
        int rx;
        if (!rstn) begin
            busy_q   = 1'b0;
            in_burst = 1'b0;
            started  = 1'b0;
        end else begin
            if (!started) begin
                if (busy || done || rx_obs.valid) begin
                    protocol_errors++;
                    $display("busy, done or rx_obs.valid set after reset before any start");
                end
                check_value("error_count after reset", 0, error_count);
            end
            if (start) begin
                started = 1'b1;
            end
            // first busy cycle is the load cycle
            if (busy && !busy_q) begin
                lfsr = 7'h7F;
                for (int k = 0; k < NUM_TAPS; k++) begin
                    tap_q[k] = $signed(taps[k]);
                    hist[k]  = 0;
                end
                exp_errors = 0;
                obs_count  = 0;
                exp_len    = burst_len;
                in_burst   = 1'b1;
            end
            if (rx_obs.valid) begin
                if (!busy) begin
                    protocol_errors++;
                    $display("rx_obs.valid seen while the link is not busy in %0s", test_name);
                end
                advance_prbs(sym);
                level = ((2 * sym - 3) * SYMBOL_SEP) / 2;
                for (int k = NUM_TAPS - 1; k > 0; k--) begin
                    hist[k] = hist[k-1];
                end
                hist[0] = level;
                acc = 0;
                for (int k = 0; k < NUM_TAPS; k++) begin
                    acc = acc + tap_q[k] * hist[k];
                end
                sample = clamp_sample(floor_scale(acc));
                rx = slice(sample);
                if (rx != sym) begin
                    exp_errors++;
                end
                obs_count++;
                check_value("tx_sym", sym, rx_obs.tx_sym);
                check_value("rx_sym", rx, rx_obs.rx_sym);
                check_value("sample", sample, $signed(rx_obs.sample));
            end
            if (done) begin
                if (!in_burst) begin
                    protocol_errors++;
                    $display("done pulse without a running burst in %0s", test_name);
                end else begin
                    check_value("error_count", exp_errors, error_count);
                    check_value("observations", exp_len, obs_count);
                    if ((exp_errors != 0) != exp_nonzero) begin
                        value_errors++;
                        $display("error %0s error class: expected %0s actual %0s", test_name,
                                 exp_nonzero ? "nonzero" : "zero",
                                 (exp_errors != 0) ? "nonzero" : "zero");
                    end
                end
                in_burst = 1'b0;
            end
            busy_q = busy;
        end
    end

endmodule

`default_nettype wire

// ==== pam4_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pam4_link_tb;
    import pam4_link_pkg::*;

    localparam int N_TAPS      = NUM_TAPS_DEF;
    localparam int SEP         = SYMBOL_SEP_DEF;
    localparam int NUM_CASES   = 8;
    localparam int IDLE_CYCLES = 5;
    localparam int RESET_LIMIT = 100;

    typedef tap_t [N_TAPS-1:0] tap_set_t;

    typedef struct packed {
        logic [8*12-1:0] name;
        tap_set_t        taps;
        logic [15:0]     len;
        logic            nonzero;
        logic            extra_start;
    } test_case_t;

    logic            clk;
    logic            rstn;
    logic            start;
    logic [15:0]     burst_len;
    tap_set_t        taps;
    logic            busy;
    logic            done;
    logic [15:0]     error_count;
    rx_obs_t         rx_obs;
    logic [8*12-1:0] test_name;
    logic            exp_nonzero;
    int              value_errors;
    int              protocol_errors;
    int              timeout_errors;
    int              assert_errors;
    test_case_t      cases [NUM_CASES];

    tb_clock_gen clock_gen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    pam4_link_top #(
        .NUM_TAPS   (N_TAPS),
        .SYMBOL_SEP (SEP)
    ) pam4_link_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .burst_len   (burst_len),
        .taps        (taps),
        .busy        (busy),
        .done        (done),
        .error_count (error_count),
        .rx_obs      (rx_obs)
    );

    pam4_link_checker #(
        .NUM_TAPS   (N_TAPS),
        .SYMBOL_SEP (SEP)
    ) checker_i (
        .clk             (clk),
        .rstn            (rstn),
        .start           (start),
        .burst_len       (burst_len),
        .taps            (taps),
        .busy            (busy),
        .done            (done),
        .error_count     (error_count),
        .rx_obs          (rx_obs),
        .test_name       (test_name),
        .exp_nonzero     (exp_nonzero),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    assign assert_errors = pam4_link_top_i.link_test_fsm_i.pam4_link_sva_i.assert_errors;

    function automatic tap_set_t tap_set(int t0, int t1, int t2, int t3);
        tap_set_t t;
        t[0] = tap_t'(t0);
        t[1] = tap_t'(t1);
        t[2] = tap_t'(t2);
        t[3] = tap_t'(t3);
        return t;
    endfunction

    // a length of 0 draws a random burst length
    task automatic fill_case_table();
        cases[0] = '{"identity", tap_set(64, 0, 0, 0), 16'd40, 1'b0, 1'b0};
        // post-cursors small enough to keep every decision inside its eye
        cases[1] = '{"mild_isi", tap_set(64, 12, -6, 0), 16'd60, 1'b0, 1'b0};
        // here the post-cursors already close the inner eyes on 3,0,2
        cases[2] = '{"edge_isi", tap_set(64, 16, -8, 0), 16'd60, 1'b1, 1'b0};
        cases[3] = '{"severe_isi", tap_set(32, 48, 32, 16), 16'd60, 1'b1, 1'b0};
        // long enough to reach the 3,3,3,2 run near the end of the sequence
        cases[4] = '{"saturation", tap_set(127, 127, 127, 127), 16'd100, 1'b1, 1'b0};
        cases[5] = '{"single", tap_set(64, 0, 0, 0), 16'd1, 1'b0, 1'b0};
        cases[6] = '{"random_a", tap_set(64, 0, 0, 0), 16'd0, 1'b0, 1'b0};
        cases[7] = '{"random_b", tap_set(64, 12, -6, 0), 16'd0, 1'b0, 1'b1};
    endtask

    task automatic wait_reset_release(output bit ok);
        int n;
        n = 0;
        while (!rstn && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = rstn;
        if (!ok) begin
            timeout_errors++;
            $display("timeout: reset was not released within %0d cycles", RESET_LIMIT);
        end
    endtask

    task automatic run_case(input int idx, output bit ok);
        test_case_t tc;
        int         len;
        int         limit;
        int         n;
        tc = cases[idx];
        len = (tc.len == 16'd0) ? 8 + int'($urandom % 33) : int'(tc.len);
        limit = len + 40;
        test_name = tc.name;
        exp_nonzero = tc.nonzero;
        burst_len = 16'(len);
        taps = tc.taps;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
            // second start lands in the run phase and must be ignored
            start = tc.extra_start && (n == 3);
        end
        start = 1'b0;
        ok = done;
        if (!ok) begin
            timeout_errors++;
            $display("timeout: no done pulse for %0s within %0d cycles", tc.name, limit);
        end
        @(negedge clk);
    endtask

    initial begin
        bit ok;
        start = 1'b0;
        burst_len = 16'd0;
        taps = '0;
        test_name = "reset";
        exp_nonzero = 1'b0;
        timeout_errors = 0;
        void'($urandom(32'h6610_d347));
        fill_case_table();
        wait_reset_release(ok);
        if (ok) begin
            repeat (IDLE_CYCLES) @(negedge clk);
            for (int i = 0; i < NUM_CASES && ok; i++) begin
                run_case(i, ok);
            end
            repeat (4) @(negedge clk);
        end
        $display("errors: value %0d, protocol %0d, timeout %0d, assertion %0d",
                 value_errors, protocol_errors, timeout_errors, assert_errors);
        if (value_errors + protocol_errors + timeout_errors + assert_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
pam4_link_pkg.sv
prbs_source.sv
pam4_mapper.sv
isi_channel.sv
pam4_slicer.sv
burst_counter.sv
link_test_fsm.sv
pam4_link_top.sv
tb_clock_gen.sv
pam4_link_sva.sv
pam4_link_checker.sv
pam4_link_tb.sv
